//--- src/monitor_pkg.sv
package monitor_pkg;

        // --------------------
        // Widths
        // --------------------
        typedef logic [7:0]  trans_id_t;    // AXI ARID / RID
        typedef logic [31:0] addr_t;        // ARADDR
        typedef logic [7:0]  beat_cnt_t;    // Saturates at 255
        typedef logic [7:0]  tick_cnt_t;    // Timeout limit and slot tick count
        typedef logic [1:0]  axi_resp_t;    // RRESP

        // Event codes carried in the packet kind field
        typedef enum logic [3:0] {
                EV_NONE    = 4'd0,
                EV_COMPL   = 4'd1,    // Last beat, OKAY or EXOKAY
                EV_ERROR   = 4'd2,    // Some beat had SLVERR or DECERR
                EV_TIMEOUT = 4'd3     // Tick limit reached
        } event_kind_t;

        // Tracking slot FSM
        typedef enum logic [1:0] {
                SLOT_IDLE,
                SLOT_WAIT,            // Outstanding, beats and ticks counted
                SLOT_REPORT           // Event waiting for the reporter
        } slot_state_t;

        // Slot to reporter
        typedef struct packed {
                logic        pending;
                event_kind_t kind;
                trans_id_t   id;
                addr_t       addr;
                beat_cnt_t   beats;
        } slot_status_t;

        // Monitor bus packet, 64 bits, MSB first
        typedef struct packed {
                event_kind_t kind;
                logic [3:0]  unit_id;
                logic [7:0]  agent_id;
                trans_id_t   id;
                addr_t       addr;
                beat_cnt_t   beats;
        } monbus_pkt_t;

endpackage

//--- src/trans_intake.sv
module trans_intake
        import monitor_pkg::*;
#(
        parameter int NUM_SLOTS = 8
) (
        input  logic                 aclk,
        input  logic                 arst_n,
        input  logic                 ar_valid,
        input  logic                 ar_ready,
        input  trans_id_t            ar_id,
        input  addr_t                ar_addr,
        input  logic [3:0]           cfg_tick_div,    // Tick period minus one
        input  logic [NUM_SLOTS-1:0] occupied,
        output logic [NUM_SLOTS-1:0] alloc_onehot,
        output trans_id_t            alloc_id,
        output addr_t                alloc_addr,
        output logic                 tick,
        output logic [7:0]           active_count,
        output logic                 busy,
        output logic                 near_full
);

        logic [NUM_SLOTS-1:0] free_onehot;    // Lowest free slot
        logic                 all_full;
        logic                 ar_take;        // Handshake that gets a slot
        logic [3:0]           div_cnt;
        logic [7:0]           occ_sum;

        // --------------------
        // Slot allocation
        // --------------------
        always_comb begin
                free_onehot = '0;
                for (int i = NUM_SLOTS - 1; i >= 0; i--) begin    // Last hit wins, lowest
                        if (!occupied[i]) begin
                                free_onehot    = '0;
                                free_onehot[i] = 1'b1;
                        end
                end
        end

        assign all_full     = &occupied;                      // No slot, AR goes untracked
        assign ar_take      = ar_valid && ar_ready && !all_full;
        assign alloc_onehot = ar_take ? free_onehot : '0;
        assign alloc_id     = ar_id;                          // Captured by the slot itself
        assign alloc_addr   = ar_addr;

        // Timeout prescaler
        always_ff @(posedge aclk or negedge arst_n) begin
                if (!arst_n) begin
                        div_cnt <= '0;
                        tick    <= 1'b0;
                end else if (div_cnt == cfg_tick_div) begin
                        div_cnt <= '0;
                        tick    <= 1'b1;                      // One cycle pulse
                end else begin
                        div_cnt <= div_cnt + 4'd1;
                        tick    <= 1'b0;
                end
        end

        // --------------------
        // Occupancy
        // --------------------
        always_comb begin
                occ_sum = '0;
                for (int i = 0; i < NUM_SLOTS; i++) begin
                        occ_sum = occ_sum + 8'(occupied[i]);
                end
        end

        always_ff @(posedge aclk or negedge arst_n) begin
                if (!arst_n)
                        active_count <= '0;
                else
                        active_count <= occ_sum;              // One cycle behind slot state
        end

        assign busy      = (active_count != 8'd0);
        assign near_full = (int'(active_count) >= NUM_SLOTS - 2);

endmodule

//--- src/trans_slot.sv
module trans_slot
        import monitor_pkg::*;
(
        input  logic         aclk,
        input  logic         arst_n,
        input  logic         alloc,                // One-hot bit from intake
        input  trans_id_t    alloc_id,
        input  addr_t        alloc_addr,
        input  logic         tick,
        input  logic         r_valid,
        input  logic         r_ready,
        input  logic         r_last,
        input  trans_id_t    r_id,
        input  axi_resp_t    r_resp,
        input  tick_cnt_t    cfg_timeout_ticks,
        input  logic         cfg_compl_enable,
        input  logic         cfg_error_enable,
        input  logic         cfg_timeout_enable,
        input  logic         ack,                  // Own bit of reporter ack
        output logic         occupied,
        output slot_status_t status
);

        slot_state_t state;
        trans_id_t   id_q;
        addr_t       addr_q;
        beat_cnt_t   beats_q;
        tick_cnt_t   ticks_q;                      // Ticks since allocation
        event_kind_t kind_q;
        logic        err_q;                        // Sticky error response

        logic        beat_hit;
        logic        beat_err;
        logic        err_any;
        logic        last_hit;
        logic        timed_out;
        event_kind_t done_kind;
        logic        done_en;

        // Beat match on own ID only
        assign beat_hit  = (state == SLOT_WAIT) && r_valid && r_ready && (r_id == id_q);
        assign beat_err  = beat_hit && r_resp[1];                  // SLVERR or DECERR
        assign err_any   = err_q || beat_err;
        assign last_hit  = beat_hit && r_last;
        assign timed_out = (state == SLOT_WAIT) && !last_hit &&    // Last beat wins
                           (ticks_q >= cfg_timeout_ticks);

        // Event kind and its enable
        assign done_kind = last_hit ? (err_any ? EV_ERROR : EV_COMPL) : EV_TIMEOUT;
        assign done_en   = last_hit ? (err_any ? cfg_error_enable : cfg_compl_enable)
                                    : cfg_timeout_enable;

        // --------------------
        // Slot FSM
        // --------------------
        always_ff @(posedge aclk or negedge arst_n) begin
                if (!arst_n) begin
                        state   <= SLOT_IDLE;
                        ticks_q <= '0;
                        err_q   <= 1'b0;
                        kind_q  <= EV_NONE;
                end else begin
                        case (state)
                        SLOT_IDLE: if (alloc) begin
                                state   <= SLOT_WAIT;
                                ticks_q <= '0;           // Older ticks do not count
                                err_q   <= 1'b0;
                                kind_q  <= EV_NONE;
                        end
                        SLOT_WAIT: begin
                                if (tick && ticks_q != '1)
                                        ticks_q <= ticks_q + 8'd1;
                                if (beat_err)
                                        err_q <= 1'b1;
                                if (last_hit || timed_out) begin
                                        kind_q <= done_kind;
                                        state  <= done_en ? SLOT_REPORT : SLOT_IDLE;  // Disabled frees
                                end
                        end
                        SLOT_REPORT: if (ack) begin    // Beats and ticks ignored here
                                state  <= SLOT_IDLE;
                                kind_q <= EV_NONE;
                        end
                        default: state <= SLOT_IDLE;
                        endcase
                end
        end

        // Payload
        always_ff @(posedge aclk) begin
                if (state == SLOT_IDLE && alloc) begin
                        id_q    <= alloc_id;
                        addr_q  <= alloc_addr;
                        beats_q <= '0;
                end else if (beat_hit && beats_q != '1) begin
                        beats_q <= beats_q + 8'd1;      // Saturating, last beat included
                end
        end

        assign occupied       = (state != SLOT_IDLE);
        assign status.pending = (state == SLOT_REPORT);
        assign status.kind    = kind_q;
        assign status.id      = id_q;
        assign status.addr    = addr_q;
        assign status.beats   = beats_q;

endmodule

//--- src/event_reporter.sv
module event_reporter
        import monitor_pkg::*;
#(
        parameter int NUM_SLOTS = 8,
        parameter int UNIT_ID   = 9,     // 4 bits in packet
        parameter int AGENT_ID  = 99     // 8 bits in packet
) (
        input  logic                 aclk,
        input  logic                 arst_n,
        input  slot_status_t         status [NUM_SLOTS],
        input  logic                 monbus_ready,
        output logic [NUM_SLOTS-1:0] ack_onehot,
        output logic                 monbus_valid,
        output monbus_pkt_t          monbus_packet
);

        localparam int IDX_W = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;

        logic [IDX_W-1:0] grant_q;     // Granted slot, also the RR pointer
        logic [IDX_W-1:0] pick_idx;
        logic             pick_ok;
        logic             grant;       // Load a new packet
        logic             xfer;        // Bus transfer this edge
        logic             valid_q;
        monbus_pkt_t      pkt_q;

        // --------------------
        // Round-robin pick
        // --------------------
        always_comb begin
                int idx;
                idx      = 0;
                pick_idx = grant_q;
                pick_ok  = 1'b0;
                // Walk from far to near, nearest pending after pointer wins
                for (int i = NUM_SLOTS; i >= 1; i--) begin
                        idx = (int'(grant_q) + i) % NUM_SLOTS;
                        if (status[idx].pending) begin
                                pick_ok  = 1'b1;
                                pick_idx = IDX_W'(idx);
                        end
                end
        end

        assign xfer  = valid_q && monbus_ready;
        assign grant = !valid_q && pick_ok;     // Only when idle

        // --------------------
        // Bus control
        // --------------------
        always_ff @(posedge aclk or negedge arst_n) begin
                if (!arst_n) begin
                        valid_q <= 1'b0;
                        grant_q <= IDX_W'(NUM_SLOTS - 1);    // First search starts at slot 0
                end else if (xfer) begin
                        valid_q <= 1'b0;                     // One idle cycle before next grant
                end else if (grant) begin
                        valid_q <= 1'b1;
                        grant_q <= pick_idx;
                end
        end

        // Packet held until transfer
        always_ff @(posedge aclk) begin
                if (grant) begin
                        pkt_q.kind     <= status[pick_idx].kind;
                        pkt_q.unit_id  <= 4'(UNIT_ID);
                        pkt_q.agent_id <= 8'(AGENT_ID);
                        pkt_q.id       <= status[pick_idx].id;
                        pkt_q.addr     <= status[pick_idx].addr;
                        pkt_q.beats    <= status[pick_idx].beats;
                end
        end

        // Ack pulse at transfer, slot frees at same edge
        always_comb begin
                ack_onehot = '0;
                if (xfer)
                        ack_onehot[grant_q] = 1'b1;
        end

        assign monbus_valid  = valid_q;
        assign monbus_packet = pkt_q;

endmodule

//--- src/axi_rd_monitor.sv
module axi_rd_monitor
        import monitor_pkg::*;
#(
        parameter int NUM_SLOTS = 8,     // Outstanding reads tracked
        parameter int UNIT_ID   = 9,
        parameter int AGENT_ID  = 99
) (
        input  logic        aclk,
        input  logic        arst_n,
        // AR channel, sampled
        input  logic        ar_valid,
        input  logic        ar_ready,
        input  trans_id_t   ar_id,
        input  addr_t       ar_addr,
        // R channel, sampled
        input  logic        r_valid,
        input  logic        r_ready,
        input  trans_id_t   r_id,
        input  axi_resp_t   r_resp,
        input  logic        r_last,
        // Configuration, static during traffic
        input  logic [3:0]  cfg_tick_div,
        input  tick_cnt_t   cfg_timeout_ticks,
        input  logic        cfg_compl_enable,
        input  logic        cfg_error_enable,
        input  logic        cfg_timeout_enable,
        // Monitor bus
        input  logic        monbus_ready,
        output logic        monbus_valid,
        output monbus_pkt_t monbus_packet,
        // Occupancy
        output logic [7:0]  active_count,
        output logic        busy,
        output logic        near_full
);

        logic [NUM_SLOTS-1:0] occupied;
        logic [NUM_SLOTS-1:0] alloc_onehot;
        logic [NUM_SLOTS-1:0] ack_onehot;
        trans_id_t            alloc_id;
        addr_t                alloc_addr;
        logic                 tick;
        slot_status_t         slot_status [NUM_SLOTS];

        // --------------------
        // Intake
        // --------------------
        trans_intake #(
                .NUM_SLOTS    (NUM_SLOTS)
        ) u_intake (
                .aclk         (aclk),
                .arst_n       (arst_n),
                .ar_valid     (ar_valid),
                .ar_ready     (ar_ready),
                .ar_id        (ar_id),
                .ar_addr      (ar_addr),
                .cfg_tick_div (cfg_tick_div),
                .occupied     (occupied),
                .alloc_onehot (alloc_onehot),
                .alloc_id     (alloc_id),
                .alloc_addr   (alloc_addr),
                .tick         (tick),
                .active_count (active_count),
                .busy         (busy),
                .near_full    (near_full)
        );

        // --------------------
        // Tracking slots
        // --------------------
        for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
                trans_slot u_slot (
                        .aclk               (aclk),
                        .arst_n             (arst_n),
                        .alloc              (alloc_onehot[i]),
                        .alloc_id           (alloc_id),
                        .alloc_addr         (alloc_addr),
                        .tick               (tick),
                        .r_valid            (r_valid),       // Raw R, ID match inside
                        .r_ready            (r_ready),
                        .r_last             (r_last),
                        .r_id               (r_id),
                        .r_resp             (r_resp),
                        .cfg_timeout_ticks  (cfg_timeout_ticks),
                        .cfg_compl_enable   (cfg_compl_enable),
                        .cfg_error_enable   (cfg_error_enable),
                        .cfg_timeout_enable (cfg_timeout_enable),
                        .ack                (ack_onehot[i]),
                        .occupied           (occupied[i]),
                        .status             (slot_status[i])
                );
        end

        // Reporter
        event_reporter #(
                .NUM_SLOTS     (NUM_SLOTS),
                .UNIT_ID       (UNIT_ID),
                .AGENT_ID      (AGENT_ID)
        ) u_reporter (
                .aclk          (aclk),
                .arst_n        (arst_n),
                .status        (slot_status),
                .monbus_ready  (monbus_ready),
                .ack_onehot    (ack_onehot),
                .monbus_valid  (monbus_valid),
                .monbus_packet (monbus_packet)
        );

endmodule

//--- verif/axi_rd_monitor_chk.sv
module axi_rd_monitor_chk
        import monitor_pkg::*;
#(
        parameter int NUM_SLOTS = 8
) (
        input logic        aclk,
        input logic        arst_n,
        input logic        monbus_valid,
        input logic        monbus_ready,
        input monbus_pkt_t monbus_packet,
        input logic [7:0]  active_count,
        input logic        busy,
        input logic        near_full
);
        timeunit 1ns;
        timeprecision 1ps;

        int unsigned fail_cnt = 0;    // Failed assertions so far

        // --------------------
        // Monitor bus
        // --------------------
        a_pkt_hold: assert property (@(posedge aclk) disable iff (!arst_n)
                monbus_valid && !monbus_ready |=> monbus_valid && $stable(monbus_packet))
        else begin
                fail_cnt++;
                $error("monitor packet changed or dropped under back-pressure");
        end

        // One idle cycle after each transfer
        a_gap: assert property (@(posedge aclk) disable iff (!arst_n)
                monbus_valid && monbus_ready |=> !monbus_valid)
        else begin
                fail_cnt++;
                $error("monitor valid high in the cycle after a transfer");
        end

        // --------------------
        // Occupancy
        // --------------------
        a_busy: assert property (@(posedge aclk) disable iff (!arst_n)
                busy == (active_count != 8'd0))
        else begin
                fail_cnt++;
                $error("busy does not follow active count");
        end

        a_near_full: assert property (@(posedge aclk) disable iff (!arst_n)
                near_full == (int'(active_count) >= NUM_SLOTS - 2))    // Two slots left
        else begin
                fail_cnt++;
                $error("near_full does not match its threshold");
        end

endmodule

bind axi_rd_monitor axi_rd_monitor_chk #(
        .NUM_SLOTS     (NUM_SLOTS)
) u_chk (
        .aclk          (aclk),
        .arst_n        (arst_n),
        .monbus_valid  (monbus_valid),
        .monbus_ready  (monbus_ready),
        .monbus_packet (monbus_packet),
        .active_count  (active_count),
        .busy          (busy),
        .near_full     (near_full)
);

//--- verif/axi_rd_monitor_tb.sv
module axi_rd_monitor_tb
        import monitor_pkg::*;
();
        timeunit 1ns;
        timeprecision 1ps;

        localparam int    NUM_SLOTS = 8;
        localparam int    UNIT_ID   = 9;
        localparam int    AGENT_ID  = 99;
        localparam int    PKT_WAIT  = 1000;    // Cycles allowed per expected packet
        localparam string STIM_FILE = "verif/axi_rd_monitor_stim.txt";

        logic        aclk;
        logic        arst_n;
        logic        ar_valid;
        logic        ar_ready;
        trans_id_t   ar_id;
        addr_t       ar_addr;
        logic        r_valid;
        logic        r_ready;
        trans_id_t   r_id;
        axi_resp_t   r_resp;
        logic        r_last;
        logic [3:0]  cfg_tick_div;
        tick_cnt_t   cfg_timeout_ticks;
        logic        cfg_compl_enable;
        logic        cfg_error_enable;
        logic        cfg_timeout_enable;
        logic        monbus_ready;
        logic        monbus_valid;
        monbus_pkt_t monbus_packet;
        logic [7:0]  active_count;
        logic        busy;
        logic        near_full;

        monbus_pkt_t seen_q [$];               // Transfers seen on the monitor bus
        int          errors   = 0;
        int          timeouts = 0;

        axi_rd_monitor #(
                .NUM_SLOTS (NUM_SLOTS),
                .UNIT_ID   (UNIT_ID),
                .AGENT_ID  (AGENT_ID)
        ) dut (.*);

        initial begin
                aclk = 1'b0;
                forever #2 aclk = ~aclk;       // 4 ns period
        end

        // Record every transfer, sampled mid-cycle
        always @(negedge aclk) begin
                if (arst_n && monbus_valid && monbus_ready)
                        seen_q.push_back(monbus_packet);
        end

        // --------------------
        // Compare tasks
        // --------------------
        task automatic check_pkt(input string name, input monbus_pkt_t exp, input monbus_pkt_t act);
                if (exp !== act) begin
                        errors++;
                        $display("mismatch %0s expected %h actual %h", name, exp, act);
                end
        endtask

        task automatic check_count(input string name, input logic [7:0] exp, input logic [7:0] act);
                if (exp !== act) begin
                        errors++;
                        $display("mismatch %0s expected %0d actual %0d", name, exp, act);
                end
        endtask

        task automatic check_flag(input string name, input logic exp, input logic act);
                if (exp !== act) begin
                        errors++;
                        $display("mismatch %0s expected %b actual %b", name, exp, act);
                end
        endtask

        // --------------------
        // Drivers
        // --------------------
        task automatic send_ar(input trans_id_t id, input addr_t addr);
                @(posedge aclk);
                ar_valid <= 1'b1;
                ar_id    <= id;
                ar_addr  <= addr;
                @(posedge aclk);               // Handshake taken here
                ar_valid <= 1'b0;
        endtask

        task automatic send_beat(input trans_id_t id, input axi_resp_t resp, input logic last);
                @(posedge aclk);
                r_valid <= 1'b1;
                r_id    <= id;
                r_resp  <= resp;
                r_last  <= last;
                @(posedge aclk);
                r_valid <= 1'b0;
                r_last  <= 1'b0;
        endtask

        task automatic expect_pkt(input string name, input monbus_pkt_t exp);
                int waited;
                waited = 0;
                while (seen_q.size() == 0 && waited < PKT_WAIT) begin
                        @(posedge aclk);
                        waited++;
                end
                if (seen_q.size() == 0) begin
                        timeouts++;
                        $display("timeout: no monitor packet for %0s after %0d cycles",
                                 name, waited);
                end else begin
                        check_pkt(name, exp, seen_q.pop_front());
                end
        endtask

        // Stimulus line with fewer fields than its command needs
        task automatic report_short_line(input string kind, input int got, input int want);
                if (got != want) begin
                        errors++;
                        $display("stimulus line %0s has %0d of its %0d fields", kind, got, want);
                end
        endtask

        // --------------------
        // Stimulus from file
        // --------------------
        initial begin
                int              fd;
                int              rc;
                int              asserts;
                logic [8*8-1:0]  cmd;
                logic [8*24-1:0] name_r;
                logic [8*128-1:0] line;
                string           tname;
                logic [7:0]      v_a;
                logic [7:0]      v_b;
                logic [7:0]      v_c;
                logic [7:0]      v_d;
                logic [7:0]      v_e;
                trans_id_t       v_id;
                addr_t           v_addr;
                logic [7:0]      v_n;
                monbus_pkt_t     exp;

                ar_valid           = 1'b0;
                ar_ready           = 1'b0;
                ar_id              = '0;
                ar_addr            = '0;
                r_valid            = 1'b0;
                r_ready            = 1'b0;
                r_id               = '0;
                r_resp             = '0;
                r_last             = 1'b0;
                cfg_tick_div       = '0;
                cfg_timeout_ticks  = '1;
                cfg_compl_enable   = 1'b1;
                cfg_error_enable   = 1'b1;
                cfg_timeout_enable = 1'b1;
                monbus_ready       = 1'b0;
                arst_n             = 1'b0;
                repeat (10) @(posedge aclk);
                arst_n       <= 1'b1;
                ar_ready     <= 1'b1;
                r_ready      <= 1'b1;
                monbus_ready <= 1'b1;

                fd = $fopen(STIM_FILE, "r");
                if (fd == 0) begin
                        errors++;
                        $display("could not open the stimulus file %0s", STIM_FILE);
                end else begin
                        while ($fscanf(fd, "%s", cmd) == 1) begin
                                if (cmd == "#") begin
                                        rc = $fgets(line, fd);       // Comment line
                                end else if (cmd == "cfg") begin
                                        rc = $fscanf(fd, "%h %h %h %h %h",
                                                     v_a, v_b, v_c, v_d, v_e);
                                        report_short_line("cfg", rc, 5);
                                        @(posedge aclk);
                                        cfg_tick_div       <= v_a[3:0];
                                        cfg_timeout_ticks  <= v_b;
                                        cfg_compl_enable   <= v_c[0];
                                        cfg_error_enable   <= v_d[0];
                                        cfg_timeout_enable <= v_e[0];
                                end else if (cmd == "ar") begin
                                        rc = $fscanf(fd, "%h %h %h", v_id, v_addr, v_n);
                                        report_short_line("ar", rc, 3);
                                        for (int i = 0; i < int'(v_n); i++)
                                                send_ar(v_id + 8'(i), v_addr + 32'(i) * 32'h40);
                                end else if (cmd == "rd") begin
                                        rc = $fscanf(fd, "%h %h %h %h", v_id, v_b, v_c, v_n);
                                        report_short_line("rd", rc, 4);
                                        for (int i = 0; i < int'(v_n); i++) begin
                                                for (int b = 1; b <= int'(v_b); b++) begin
                                                        // SLVERR on the chosen beat
                                                        send_beat(v_id + 8'(i),
                                                                  (b == int'(v_c)) ? 2'b10 : 2'b00,
                                                                  b == int'(v_b));
                                                end
                                        end
                                end else if (cmd == "idle") begin
                                        rc = $fscanf(fd, "%h", v_n);
                                        report_short_line("idle", rc, 1);
                                        repeat (int'(v_n)) @(posedge aclk);
                                end else if (cmd == "ready") begin
                                        rc = $fscanf(fd, "%h", v_a);
                                        report_short_line("ready", rc, 1);
                                        @(posedge aclk);
                                        monbus_ready <= v_a[0];
                                end else if (cmd == "pkt") begin
                                        rc = $fscanf(fd, "%s %h %h %h %h %h", name_r, v_a, v_id,
                                                     v_addr, v_b, v_n);
                                        report_short_line("pkt", rc, 6);
                                        tname = $sformatf("%0s", name_r);
                                        for (int i = 0; i < int'(v_n); i++) begin
                                                exp.kind     = event_kind_t'(v_a[3:0]);
                                                exp.unit_id  = 4'(UNIT_ID);
                                                exp.agent_id = 8'(AGENT_ID);
                                                exp.id       = v_id + 8'(i);
                                                exp.addr     = v_addr + 32'(i) * 32'h40;
                                                exp.beats    = v_b;
                                                expect_pkt(tname, exp);
                                        end
                                end else if (cmd == "cnt") begin
                                        rc = $fscanf(fd, "%s %h %h %h", name_r, v_a, v_b, v_c);
                                        report_short_line("cnt", rc, 4);
                                        tname = $sformatf("%0s", name_r);
                                        @(negedge aclk);
                                        check_count({tname, ".count"}, v_a, active_count);
                                        check_flag({tname, ".busy"}, v_b[0], busy);
                                        check_flag({tname, ".near_full"}, v_c[0], near_full);
                                end else begin
                                        errors++;
                                        $display("unknown stimulus command %0s", cmd);
                                        rc = $fgets(line, fd);
                                end
                        end
                        $fclose(fd);
                end

                repeat (20) @(posedge aclk);
                if (seen_q.size() != 0) begin
                        errors++;
                        $display("%0d monitor packets arrived that no test expected",
                                 seen_q.size());
                end
                asserts = int'(dut.u_chk.fail_cnt);
                $display("closing: %0d errors, %0d timeouts, %0d assertion failures",
                         errors, timeouts, asserts);
                if (errors == 0 && timeouts == 0 && asserts == 0)
                        $display("*** PASSED ***");
                else
                        $display("*** FAILED ***");
                $finish;
        end

endmodule

//--- axi_rd_monitor.f
src/monitor_pkg.sv
src/trans_intake.sv
src/trans_slot.sv
src/event_reporter.sv
src/axi_rd_monitor.sv
verif/axi_rd_monitor_chk.sv
verif/axi_rd_monitor_tb.sv

//--- Makefile
# Verilator build and run of the AXI read monitor testbench

BIN  := obj_dir/Vaxi_rd_monitor_tb
SRCS := $(shell cat axi_rd_monitor.f)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): axi_rd_monitor.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module axi_rd_monitor_tb -f axi_rd_monitor.f

run: $(BIN)
	./$(BIN) +verilator+error+limit+100 | tee sim.log
	grep -qF '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

//--- verif/axi_rd_monitor_stim.txt
# cfg tick_div timeout_ticks compl_en err_en to_en | ar id addr n | rd id beats err_beat n
# idle n | ready v | pkt name kind id addr beats n | cnt name count busy near_full (hex)
cfg 3 20 1 1 1
ar 11 10000100 1
rd 11 4 0 1
pkt t1_single_compl 1 11 10000100 4 1
ar 21 2000 1
ar 22 2100 1
rd 22 2 0 1
rd 21 3 0 1
pkt t2_first_answer 1 22 2100 2 1
pkt t2_second_answer 1 21 2000 3 1
ar 31 3000 1
rd 31 4 2 1
pkt t3_slverr 2 31 3000 4 1
cfg 3 20 1 0 1
ar 32 3100 1
rd 32 3 2 1
idle 4
cnt t3_err_disabled 0 0 0
cfg 3 20 1 1 1
ar 40 4000 1
pkt t4_timeout 3 40 4000 0 1
ready 0
ar 50 5000 3
rd 50 2 0 3
idle 8
cnt t5_held 3 1 0
ready 1
pkt t5_drain 1 50 5000 2 3
idle 4
cnt t5_empty 0 0 0
ar 60 6000 7
idle 2
cnt t6_seven_open 7 1 1
rd 60 1 0 7
pkt t6_drain 1 60 6000 1 7
idle 4
cnt t6_empty 0 0 0
